/* rtl/lvds_tx_config.svh */
`ifndef LVDS_TX_CONFIG_SVH
`define LVDS_TX_CONFIG_SVH

////////////////////
// Link geometry
////////////////////

// Ports sending one pixel each per slot
`define LVDS_PORT_NUM 2

// Bits per lane in one pixel slot
`define LVDS_SLOT_LEN 7

////////////////////
// Buffering
////////////////////

// Pixel FIFO entries, equal to the source's initial credit
`define LVDS_FIFO_DEPTH 8

`endif

/* rtl/lvds_tx_pkg.sv */
`include "lvds_tx_config.svh"

package lvds_tx_pkg;

    // One 8-bit colour component
    typedef logic [7:0] colour_t;

    // One serial lane word, bit 0 goes out first
    typedef logic [`LVDS_SLOT_LEN-1:0] lane_word_t;

    ////////////////////
    // Pixel record
    ////////////////////

    // One FIFO entry, packed {de, vs, hs, b, g, r}
    // r, g and b are 8 bits per port with port 0 lowest
    // Sync and enable bits are shared by all ports
    typedef logic [24*`LVDS_PORT_NUM+3-1:0] pixel_bus_t;

    ////////////////////
    // Lane words
    ////////////////////

    // Four words per port, port 0 lowest, lane 0 lowest within a port
    typedef logic [28*`LVDS_PORT_NUM-1:0] lane_bus_t;

    // Wide enough for 0 .. FIFO depth
    typedef logic [$clog2(`LVDS_FIFO_DEPTH+1)-1:0] credit_cnt_t;

endpackage

/* rtl/pixel_credit_fifo.sv */
`timescale 1ns/1ps
`include "lvds_tx_config.svh"

module pixel_credit_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  lvds_tx_pkg::pixel_bus_t push_pixel,
    input  logic                    pop,
    output lvds_tx_pkg::pixel_bus_t head_pixel,
    output logic                    not_empty,
    output logic                    credit_return
);

    localparam int DEPTH = `LVDS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $bits(lvds_tx_pkg::credit_cnt_t);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    lvds_tx_pkg::pixel_bus_t  mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    lvds_tx_pkg::credit_cnt_t count;
    logic                     do_pop;

    // Popping an empty FIFO is ignored
    assign do_pop = pop && not_empty;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pixel;
        end
    end

    assign head_pixel = mem[rd_ptr];
    assign not_empty  = (count != '0);

    ////////////////////
    // Pointers and occupancy
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back per popped entry, a cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;
        end
    end

    ////////////////////
    // Protocol checks
    ////////////////////

    // Source must have run out of credits before the FIFO fills
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (count != lvds_tx_pkg::credit_cnt_t'(DEPTH))
    ) else $error("pixel_credit_fifo push while full");

    // Stored entries plus the credit still in flight stay within the pool
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((CNT_W+1)'(count) + (CNT_W+1)'(credit_return)) <= (CNT_W+1)'(DEPTH)
    ) else $error("pixel_credit_fifo occupancy and credits exceed depth");

endmodule

/* rtl/vesa_lane_mapper.sv */
`timescale 1ns/1ps
`include "lvds_tx_config.svh"

// VESA 24-bit lane assignment, first bit sent on the left
//   lane 0 : R0 R1 R2 R3 R4 R5 G0
//   lane 1 : G1 G2 G3 G4 G5 B0 B1
//   lane 2 : B2 B3 B4 B5 HS VS DE
//   lane 3 : R6 R7 G6 G7 B6 B7 0

module vesa_lane_mapper (
    input  lvds_tx_pkg::pixel_bus_t pixel,
    output lvds_tx_pkg::lane_bus_t  lane_words
);

    localparam int PORT_NUM = `LVDS_PORT_NUM;
    localparam int SLOT_LEN = `LVDS_SLOT_LEN;

    // Field offsets inside the pixel record
    localparam int G_LSB  = 8 * PORT_NUM;
    localparam int B_LSB  = 16 * PORT_NUM;
    localparam int HS_BIT = 24 * PORT_NUM;
    localparam int VS_BIT = HS_BIT + 1;
    localparam int DE_BIT = HS_BIT + 2;

    logic hs;
    logic vs;
    logic de;

    assign hs = pixel[HS_BIT];
    assign vs = pixel[VS_BIT];
    assign de = pixel[DE_BIT];

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        lvds_tx_pkg::colour_t    r;
        lvds_tx_pkg::colour_t    g;
        lvds_tx_pkg::colour_t    b;
        lvds_tx_pkg::lane_word_t lane0;
        lvds_tx_pkg::lane_word_t lane1;
        lvds_tx_pkg::lane_word_t lane2;
        lvds_tx_pkg::lane_word_t lane3;

        assign r = pixel[8*p +: 8];
        assign g = pixel[G_LSB + 8*p +: 8];
        assign b = pixel[B_LSB + 8*p +: 8];

        // Low six colour bits on lanes 0 to 2
        assign lane0 = {g[0], r[5:0]};
        assign lane1 = {b[1:0], g[5:1]};
        assign lane2 = {de, vs, hs, b[5:2]};

        // MSB pairs on lane 3, last slot bit unused
        assign lane3 = {1'b0, b[7:6], g[7:6], r[7:6]};

        assign lane_words[(4*p+0)*SLOT_LEN +: SLOT_LEN] = lane0;
        assign lane_words[(4*p+1)*SLOT_LEN +: SLOT_LEN] = lane1;
        assign lane_words[(4*p+2)*SLOT_LEN +: SLOT_LEN] = lane2;
        assign lane_words[(4*p+3)*SLOT_LEN +: SLOT_LEN] = lane3;
    end

endmodule

/* rtl/lane_serializer.sv */
`timescale 1ns/1ps
`include "lvds_tx_config.svh"

module lane_serializer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        not_empty,
    input  lvds_tx_pkg::lane_bus_t      lane_words,
    output logic                        pop,
    output logic [4*`LVDS_PORT_NUM-1:0] lane_out,
    output logic                        clk_lane
);

    localparam int LANE_NUM = 4 * `LVDS_PORT_NUM;
    localparam int SLOT_LEN = `LVDS_SLOT_LEN;
    localparam int CNT_W    = $clog2(SLOT_LEN);
    localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(SLOT_LEN - 1);

    // 1,1,0,0,0,1,1 over the slot, bit 0 first
    localparam lvds_tx_pkg::lane_word_t CLK_PATTERN = lvds_tx_pkg::lane_word_t'(7'b1100011);

    logic [CNT_W-1:0]        slot_cnt;
    logic                    slot_end;

    // Data lanes first, the clock lane sits at index LANE_NUM
    lvds_tx_pkg::lane_word_t shreg     [LANE_NUM+1];
    lvds_tx_pkg::lane_word_t load_word [LANE_NUM+1];

    ////////////////////
    // Slot counter
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
        end else if (slot_end) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    assign slot_end = (slot_cnt == SLOT_LAST);

    // Take the head pixel only at the slot boundary
    assign pop = slot_end && not_empty;

    ////////////////////
    // Next slot words
    ////////////////////

    always_comb begin
        for (int i = 0; i < LANE_NUM; i++) begin
            // Idle slot sends zeros on every data lane
            load_word[i] = not_empty ? lane_words[i*SLOT_LEN +: SLOT_LEN] : '0;
        end
        load_word[LANE_NUM] = CLK_PATTERN;
    end

    ////////////////////
    // Shift registers
    ////////////////////

    // Lanes stay low until the first slot boundary after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= LANE_NUM; i++) begin
                shreg[i] <= '0;
            end
        end else begin
            for (int i = 0; i <= LANE_NUM; i++) begin
                if (slot_end) begin
                    shreg[i] <= load_word[i];
                end else begin
                    shreg[i] <= shreg[i] >> 1;
                end
            end
        end
    end

    ////////////////////
    // Line outputs
    ////////////////////

    always_comb begin
        for (int i = 0; i < LANE_NUM; i++) begin
            lane_out[i] = shreg[i][0];
        end
    end

    assign clk_lane = shreg[LANE_NUM][0];

endmodule

/* rtl/lvds_tx_top.sv */
`timescale 1ns/1ps
`include "lvds_tx_config.svh"

module lvds_tx_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pix_valid,
    input  logic [8*`LVDS_PORT_NUM-1:0] r,
    input  logic [8*`LVDS_PORT_NUM-1:0] g,
    input  logic [8*`LVDS_PORT_NUM-1:0] b,
    input  logic                        hs,
    input  logic                        vs,
    input  logic                        de,
    output logic                        credit_return,
    output logic [4*`LVDS_PORT_NUM-1:0] lane_out,
    output logic                        clk_lane
);

    lvds_tx_pkg::pixel_bus_t push_pixel;
    lvds_tx_pkg::pixel_bus_t head_pixel;
    lvds_tx_pkg::lane_bus_t  lane_words;
    logic                    not_empty;
    logic                    pop;

    // Same field order as the FIFO entry layout
    assign push_pixel = {de, vs, hs, b, g, r};

    ////////////////////
    // Pixel buffering
    ////////////////////

    pixel_credit_fifo u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (pix_valid),
        .push_pixel    (push_pixel),
        .pop           (pop),
        .head_pixel    (head_pixel),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    ////////////////////
    // Lane mapping
    ////////////////////

    // Works on the FIFO head so words are ready at slot end
    vesa_lane_mapper u_mapper (
        .pixel      (head_pixel),
        .lane_words (lane_words)
    );

    ////////////////////
    // Serial output
    ////////////////////

    lane_serializer u_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .not_empty  (not_empty),
        .lane_words (lane_words),
        .pop        (pop),
        .lane_out   (lane_out),
        .clk_lane   (clk_lane)
    );

endmodule

/* verification/lvds_tx_tb.sv */
`timescale 1ns/1ps
`include "lvds_tx_config.svh"

module lvds_tx_tb;

    localparam int PORT_NUM     = `LVDS_PORT_NUM;
    localparam int LANE_NUM     = 4 * PORT_NUM;
    localparam int SLOT_LEN     = `LVDS_SLOT_LEN;
    localparam int DEPTH        = `LVDS_FIFO_DEPTH;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int TBL_LEN      = 24;
    localparam int BURST_FIRST  = 8;
    localparam int BURST_LAST   = 19;
    localparam int TIMEOUT_NS   = TBL_LEN * SLOT_LEN * 16 * CLK_PERIOD + 2000;

    localparam lvds_tx_pkg::lane_word_t CLK_PATTERN = 7'b1100011;

    logic                    clk;
    logic                    rst_n;
    logic                    pix_valid;
    logic [8*PORT_NUM-1:0]   r;
    logic [8*PORT_NUM-1:0]   g;
    logic [8*PORT_NUM-1:0]   b;
    logic                    hs;
    logic                    vs;
    logic                    de;
    logic                    credit_return;
    logic [LANE_NUM-1:0]     lane_out;
    logic                    clk_lane;

    // Stimulus table with expected lane words per entry
    logic [8*PORT_NUM-1:0]   tbl_r   [TBL_LEN];
    logic [8*PORT_NUM-1:0]   tbl_g   [TBL_LEN];
    logic [8*PORT_NUM-1:0]   tbl_b   [TBL_LEN];
    logic                    tbl_hs  [TBL_LEN];
    logic                    tbl_vs  [TBL_LEN];
    logic                    tbl_de  [TBL_LEN];
    lvds_tx_pkg::lane_bus_t  tbl_exp [TBL_LEN];
    int                      tbl_fill;

    int                       exp_idx_q [$];
    lvds_tx_pkg::credit_cnt_t credits;
    logic [15:0]              lfsr_state;
    int                       sent_count;
    int                       returned_count;
    int                       rx_count;
    int                       idle_slots;
    int                       idle_before;
    int                       value_errors;
    int                       protocol_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lvds_tx_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid),
        .r             (r),
        .g             (g),
        .b             (b),
        .hs            (hs),
        .vs            (vs),
        .de            (de),
        .credit_return (credit_return),
        .lane_out      (lane_out),
        .clk_lane      (clk_lane)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // VESA 24-bit rule built bit by bit with bit 0 sent first
    function automatic lvds_tx_pkg::lane_bus_t vesa_expect(
        input logic [8*PORT_NUM-1:0] rr,
        input logic [8*PORT_NUM-1:0] gg,
        input logic [8*PORT_NUM-1:0] bb,
        input logic h,
        input logic v,
        input logic d
    );
        lvds_tx_pkg::lane_bus_t  words;
        lvds_tx_pkg::lane_word_t w [4];
        lvds_tx_pkg::colour_t    rc;
        lvds_tx_pkg::colour_t    gc;
        lvds_tx_pkg::colour_t    bc;
        words = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            rc = rr[8*p +: 8];
            gc = gg[8*p +: 8];
            bc = bb[8*p +: 8];
            for (int k = 0; k < 6; k++) w[0][k] = rc[k];
            w[0][6] = gc[0];
            for (int k = 0; k < 5; k++) w[1][k] = gc[k+1];
            w[1][5] = bc[0];
            w[1][6] = bc[1];
            for (int k = 0; k < 4; k++) w[2][k] = bc[k+2];
            w[2][4] = h;
            w[2][5] = v;
            w[2][6] = d;
            w[3][0] = rc[6];
            w[3][1] = rc[7];
            w[3][2] = gc[6];
            w[3][3] = gc[7];
            w[3][4] = bc[6];
            w[3][5] = bc[7];
            w[3][6] = 1'b0;
            for (int l = 0; l < 4; l++) begin
                words[(4*p+l)*SLOT_LEN +: SLOT_LEN] = w[l];
            end
        end
        return words;
    endfunction

    task automatic add_entry(
        input logic [8*PORT_NUM-1:0] rr,
        input logic [8*PORT_NUM-1:0] gg,
        input logic [8*PORT_NUM-1:0] bb,
        input logic h,
        input logic v,
        input logic d
    );
        tbl_r[tbl_fill]   = rr;
        tbl_g[tbl_fill]   = gg;
        tbl_b[tbl_fill]   = bb;
        tbl_hs[tbl_fill]  = h;
        tbl_vs[tbl_fill]  = v;
        tbl_de[tbl_fill]  = d;
        tbl_exp[tbl_fill] = vesa_expect(rr, gg, bb, h, v, d);
        tbl_fill++;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        value_errors++;
        $display("error: %s expected %h actual %h", name, exp, act);
    endtask

    task automatic check_quiet_outputs(input string phase);
        if (lane_out !== '0) report_mismatch({phase, " lane_out"}, 0, lane_out);
        if (clk_lane !== 1'b0) report_mismatch({phase, " clk_lane"}, 0, clk_lane);
        if (credit_return !== 1'b0) report_mismatch({phase, " credit_return"}, 0, credit_return);
    endtask

    // Advance the source one cycle and count returned credits
    task automatic next_cycle();
        @(negedge clk);
        if (credit_return === 1'b1) begin
            returned_count++;
            if (credits == DEPTH) begin
                protocol_errors++;
                $display("A credit came back while the source already held all of them");
            end else begin
                credits++;
            end
        end
    endtask

    task automatic drive_pixel(input int idx);
        r  = tbl_r[idx];
        g  = tbl_g[idx];
        b  = tbl_b[idx];
        hs = tbl_hs[idx];
        vs = tbl_vs[idx];
        de = tbl_de[idx];
        pix_valid = 1'b1;
        credits--;
        sent_count++;
        exp_idx_q.push_back(idx);
    endtask

    task automatic run_source();
        int gap;
        for (int i = 0; i < TBL_LEN; i++) begin
            // Middle of the table goes back to back until credits run dry
            if (i >= BURST_FIRST && i <= BURST_LAST) begin
                gap = 0;
            end else begin
                take_bits(4, gap);
            end
            repeat (gap) next_cycle();
            while (credits == 0) next_cycle();
            drive_pixel(i);
            next_cycle();
            pix_valid = 1'b0;
        end
    endtask

    ////////////////////
    // Lane monitor
    ////////////////////

    task automatic check_slot(input lvds_tx_pkg::lane_bus_t rx_bus,
                              input lvds_tx_pkg::lane_word_t rx_clk, input int slot);
        int idx;
        int base;
        if (rx_clk !== CLK_PATTERN) begin
            report_mismatch($sformatf("slot %0d clk_lane", slot), CLK_PATTERN, rx_clk);
        end
        if (rx_bus === '0) begin
            idle_slots++;
        end else if (exp_idx_q.size() == 0) begin
            protocol_errors++;
            $display("Pixel data on the lanes in slot %0d with no pixel outstanding", slot);
        end else begin
            idx = exp_idx_q.pop_front();
            for (int p = 0; p < PORT_NUM; p++) begin
                for (int l = 0; l < 4; l++) begin
                    base = (4*p+l) * SLOT_LEN;
                    if (rx_bus[base +: SLOT_LEN] !== tbl_exp[idx][base +: SLOT_LEN]) begin
                        report_mismatch($sformatf("pixel %0d port %0d lane %0d", idx, p, l),
                                        tbl_exp[idx][base +: SLOT_LEN],
                                        rx_bus[base +: SLOT_LEN]);
                    end
                end
            end
            rx_count++;
        end
    endtask

    initial begin : lane_monitor
        lvds_tx_pkg::lane_bus_t  rx_bus;
        lvds_tx_pkg::lane_word_t rx_clk;
        logic                    prev_clk;
        logic                    aligned;
        logic                    partial;
        int                      bit_idx;
        int                      slot;
        prev_clk = 1'b0;
        aligned  = 1'b0;
        partial  = 1'b0;
        bit_idx  = 0;
        slot     = 0;
        rx_bus   = '0;
        rx_clk   = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (!aligned) begin
                // The 1 to 0 step of the clock lane sits between bits 1 and 2
                if (prev_clk && !clk_lane) begin
                    aligned = 1'b1;
                    partial = 1'b1;
                    bit_idx = 3;
                end
                prev_clk = clk_lane;
            end else begin
                for (int l = 0; l < LANE_NUM; l++) begin
                    rx_bus[l*SLOT_LEN + bit_idx] = lane_out[l];
                end
                rx_clk[bit_idx] = clk_lane;
                bit_idx++;
                if (bit_idx == SLOT_LEN) begin
                    if (!partial) begin
                        slot++;
                        check_slot(rx_bus, rx_clk, slot);
                    end
                    partial = 1'b0;
                    bit_idx = 0;
                end
            end
        end
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d pixels received",
                 TIMEOUT_NS, rx_count, TBL_LEN);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        pix_valid       = 1'b0;
        r               = '0;
        g               = '0;
        b               = '0;
        hs              = 1'b0;
        vs              = 1'b0;
        de              = 1'b0;
        credits         = DEPTH;
        lfsr_state      = 16'd21097;
        tbl_fill        = 0;
        sent_count      = 0;
        returned_count  = 0;
        rx_count        = 0;
        idle_slots      = 0;
        value_errors    = 0;
        protocol_errors = 0;

        // Port 1 in the upper byte of each colour
        add_entry(16'h3c_a5, 16'h5a_0f, 16'hc3_f0, 1'b0, 1'b0, 1'b1);
        add_entry(16'hff_01, 16'h00_80, 16'h7e_40, 1'b0, 1'b0, 1'b1);
        add_entry(16'h00_00, 16'h00_00, 16'h00_00, 1'b1, 1'b0, 1'b0);
        add_entry(16'h00_00, 16'h00_00, 16'h00_00, 1'b1, 1'b1, 1'b0);
        add_entry(16'h80_40, 16'h20_10, 16'h08_04, 1'b0, 1'b0, 1'b1);
        add_entry(16'hc0_00, 16'h00_c0, 16'h00_00, 1'b0, 1'b0, 1'b1);
        add_entry(16'h01_02, 16'h04_08, 16'h10_20, 1'b0, 1'b0, 1'b1);
        add_entry(16'hff_ff, 16'hff_ff, 16'hff_ff, 1'b1, 1'b1, 1'b1);
        add_entry(16'h12_34, 16'h56_78, 16'h9a_bc, 1'b0, 1'b0, 1'b1);
        add_entry(16'hde_f0, 16'h13_57, 16'h9b_df, 1'b0, 1'b0, 1'b1);
        add_entry(16'h24_68, 16'hac_e0, 16'h11_22, 1'b0, 1'b0, 1'b1);
        add_entry(16'h33_44, 16'h55_66, 16'h77_88, 1'b0, 1'b0, 1'b1);
        add_entry(16'h99_aa, 16'hbb_cc, 16'hdd_ee, 1'b0, 1'b0, 1'b1);
        add_entry(16'h0f_f0, 16'hf0_0f, 16'h3c_c3, 1'b1, 1'b0, 1'b1);
        add_entry(16'h7f_fe, 16'h01_80, 16'he7_18, 1'b0, 1'b1, 1'b1);
        add_entry(16'h55_aa, 16'haa_55, 16'h5a_a5, 1'b0, 1'b0, 1'b1);
        add_entry(16'h81_42, 16'h24_18, 16'h18_24, 1'b0, 1'b0, 1'b1);
        add_entry(16'h6d_b6, 16'hdb_6d, 16'hb6_db, 1'b0, 1'b0, 1'b1);
        add_entry(16'h02_00, 16'h00_00, 16'h00_00, 1'b0, 1'b0, 1'b0);
        add_entry(16'h00_00, 16'h00_00, 16'h00_01, 1'b0, 1'b0, 1'b0);
        add_entry(16'hc8_37, 16'h91_6e, 16'h4b_b4, 1'b0, 1'b0, 1'b1);
        add_entry(16'h00_00, 16'h00_00, 16'h00_00, 1'b0, 1'b1, 1'b0);
        add_entry(16'hfe_ef, 16'h10_01, 16'h0a_a0, 1'b1, 1'b0, 1'b1);
        add_entry(16'h29_92, 16'h63_36, 16'hc5_5c, 1'b0, 1'b0, 1'b1);

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet_outputs("reset");
        end
        rst_n = 1'b1;

        // First slot after release is still empty
        repeat (SLOT_LEN - 1) begin
            @(negedge clk);
            check_quiet_outputs("after reset");
        end

        run_source();

        while (rx_count != TBL_LEN) next_cycle();
        idle_before = idle_slots;
        repeat (2 * SLOT_LEN) next_cycle();

        if (returned_count != sent_count) begin
            report_mismatch("credit pulses", sent_count, returned_count);
        end
        if (credits != DEPTH) report_mismatch("final credits", DEPTH, credits);
        if (idle_slots <= idle_before) begin
            protocol_errors++;
            $display("Lanes did not go idle after the FIFO drained");
        end

        $display("Error counts: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* lvds_tx.f */
+incdir+rtl
rtl/lvds_tx_pkg.sv
rtl/pixel_credit_fifo.sv
rtl/vesa_lane_mapper.sv
rtl/lane_serializer.sv
rtl/lvds_tx_top.sv
verification/lvds_tx_tb.sv

/* Bender.yml */
package:
  name: lvds_tx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lvds_tx_pkg.sv
      - rtl/pixel_credit_fifo.sv
      - rtl/vesa_lane_mapper.sv
      - rtl/lane_serializer.sv
      - rtl/lvds_tx_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/lvds_tx_tb.sv
